/* hdl/rv32i_types_pkg.sv */
package rv32i_types_pkg;

  // Basic data word of the core
  typedef logic [31:0] word_t;

  // CSR access kinds seen from the pipeline
  typedef enum logic [1:0] {
    CSR_NONE = 2'b00,
    CSR_SWAP = 2'b01,  // csrrw
    CSR_SET  = 2'b10,  // csrrs
    CSR_CLR  = 2'b11   // csrrc
  } csr_op_t;

  // One CSR access per cycle
  typedef struct packed {
    csr_op_t     op;
    logic [11:0] addr;
    word_t       wdata;
  } csr_req_t;

  // Exceptions raised by the pipeline for the current instruction
  typedef struct packed {
    logic  fetch_misaligned;
    logic  illegal_insn;
    logic  breakpoint;
    logic  load_misaligned;
    logic  store_misaligned;
    logic  ecall;
    word_t epc;      // PC of the faulting instruction
    word_t badaddr;  // Offending address for misaligned accesses
    logic  mret;
  } exc_t;

endpackage

/* hdl/machine_mode_types_pkg.sv */
package machine_mode_types_pkg;

  // Machine information registers
  localparam logic [11:0] MCPUID   = 12'hF00;
  localparam logic [11:0] MIMPID   = 12'hF01;
  localparam logic [11:0] MHARTID  = 12'hF10;

  // Machine trap setup
  localparam logic [11:0] MSTATUS  = 12'h300;
  localparam logic [11:0] MTVEC    = 12'h301;
  localparam logic [11:0] MTDELEG  = 12'h302;
  localparam logic [11:0] MIE      = 12'h304;

  // Machine trap handling
  localparam logic [11:0] MSCRATCH = 12'h340;
  localparam logic [11:0] MEPC     = 12'h341;
  localparam logic [11:0] MCAUSE   = 12'h342;
  localparam logic [11:0] MBADADDR = 12'h343;
  localparam logic [11:0] MIP      = 12'h344;

  // Protection and translation, not implemented
  localparam logic [11:0] MBASE    = 12'h380;
  localparam logic [11:0] MBOUND   = 12'h381;
  localparam logic [11:0] MIBASE   = 12'h382;
  localparam logic [11:0] MIBOUND  = 12'h383;
  localparam logic [11:0] MDBASE   = 12'h384;
  localparam logic [11:0] MDBOUND  = 12'h385;

  // Hypervisor timer shadows
  localparam logic [11:0] HTIMEW   = 12'hB01;
  localparam logic [11:0] HTIMEHW  = 12'hB81;

  // Machine timers
  localparam logic [11:0] MTIMECMP = 12'h321;
  localparam logic [11:0] MTIME    = 12'h701;
  localparam logic [11:0] MTIMEH   = 12'h741;

  // Fixed field values
  localparam logic [1:0]  BASE_RV32    = 2'b00;
  localparam logic [25:0] MCPUID_EXT_I = 26'h100;  // 'I' is bit 8
  localparam logic [4:0]  VM_MBARE     = 5'd0;
  localparam logic [1:0]  XS_ALL_OFF   = 2'b00;
  localparam logic [1:0]  FS_OFF       = 2'b00;

  typedef enum logic [1:0] {
    U_MODE = 2'b00,
    S_MODE = 2'b01,
    H_MODE = 2'b10,
    M_MODE = 2'b11
  } prv_lvl_t;

  // Bit 4 marks an interrupt cause, mcause keeps it apart from the code
  typedef enum logic [4:0] {
    EXC_FETCH_MISALIGNED = 5'h00,
    EXC_ILLEGAL_INSN     = 5'h02,
    EXC_BREAKPOINT       = 5'h03,
    EXC_LOAD_MISALIGNED  = 5'h04,
    EXC_STORE_MISALIGNED = 5'h06,
    EXC_ECALL_M          = 5'h0B,
    INT_SOFT             = 5'h10,
    INT_TIMER            = 5'h11
  } cause_t;

  typedef struct packed {
    logic [1:0]  base;
    logic [3:0]  zero;
    logic [25:0] extensions;
  } mcpuid_t;

  typedef struct packed {
    logic     sd;
    logic [8:0] zero;
    logic [4:0] vm;
    logic     mprv;
    logic [1:0] xs;
    logic [1:0] fs;
    prv_lvl_t prv3;
    logic     ie3;
    prv_lvl_t prv2;
    logic     ie2;
    prv_lvl_t prv1;
    logic     ie1;
    prv_lvl_t prv;
    logic     ie;
  } mstatus_t;

  typedef struct packed {
    logic [23:0] zero_0;
    logic        mtie;
    logic        htie;
    logic        stie;
    logic        zero_1;
    logic        msie;
    logic        hsie;
    logic        ssie;
    logic        zero_2;
  } mie_t;

  typedef struct packed {
    logic [23:0] zero_0;
    logic        mtip;
    logic        htip;
    logic        stip;
    logic        zero_1;
    logic        msip;
    logic        hsip;
    logic        ssip;
    logic        zero_2;
  } mip_t;

  typedef struct packed {
    logic        interrupt;
    logic [26:0] zero;
    logic [3:0]  cause;
  } mcause_t;

  // State the trap logic needs to see
  typedef struct packed {
    logic [31:0] mtvec;
    logic [31:0] mepc;
    mie_t        mie;
    mstatus_t    mstatus;
    mip_t        mip;
  } csr_view_t;

  // Update requests from the trap logic into the register file
  typedef struct packed {
    logic        mstatus_ie_rup;
    logic        mstatus_ie_next;
    logic        mepc_rup;
    logic [31:0] mepc_next;
    logic        mcause_rup;
    mcause_t     mcause_next;
    logic        mbadaddr_rup;
    logic [31:0] mbadaddr_next;
    logic        mip_msip_next;
    logic        mip_mtip_next;
  } csr_upd_t;

endpackage

/* hdl/csr_rfile.sv */
`timescale 1ns/1ns

module csr_rfile
  import rv32i_types_pkg::*, machine_mode_types_pkg::*;
#(
  parameter word_t MTVEC_ADDR = 32'h0000_0100
) (
  input  logic      CLK,
  input  logic      nRST,
  input  csr_req_t  csr_req,
  input  csr_upd_t  csr_upd,
  output word_t     csr_rdata,
  output logic      invalid_csr,
  output csr_view_t csr_view,
  output logic      timer_int,
  output logic      clear_timer_int
);

  // Implemented state
  logic        mstatus_ie;
  logic        mie_msie;
  logic        mie_mtie;
  logic        mip_msip;
  logic        mip_mtip;
  word_t       mscratch;
  word_t       mepc;
  word_t       mbadaddr;
  word_t       mtimecmp;
  mcause_t     mcause;
  logic [63:0] mtime_full;

  // Full register images
  mcpuid_t  mcpuid;
  mstatus_t mstatus;
  mie_t     mie;
  mip_t     mip;

  logic        valid_addr;
  logic        wr_en;
  word_t       rup_data;
  mstatus_t    rup_mstatus;
  mie_t        rup_mie;
  logic [63:0] mtime_inc;

  logic wr_mstatus, wr_mie, wr_mscratch, wr_mepc;
  logic wr_mtimecmp, wr_mtime, wr_mtimeh;

  assign mcpuid.base       = BASE_RV32;
  assign mcpuid.zero       = '0;
  assign mcpuid.extensions = MCPUID_EXT_I;

  // Machine mode only, so every stacked mode is M
  always_comb begin
    mstatus      = '0;
    mstatus.vm   = VM_MBARE;
    mstatus.xs   = XS_ALL_OFF;
    mstatus.fs   = FS_OFF;
    mstatus.prv3 = M_MODE;
    mstatus.prv2 = M_MODE;
    mstatus.prv1 = M_MODE;
    mstatus.prv  = M_MODE;
    mstatus.ie   = mstatus_ie;
  end

  always_comb begin
    mie      = '0;
    mie.mtie = mie_mtie;
    mie.msie = mie_msie;
    mip      = '0;
    mip.mtip = mip_mtip;
    mip.msip = mip_msip;
  end

  // Read mux
  always_comb begin
    valid_addr = 1'b1;
    case (csr_req.addr)
      MCPUID:   csr_rdata = mcpuid;
      MIMPID:   csr_rdata = '0;
      MHARTID:  csr_rdata = '0;
      MSTATUS:  csr_rdata = mstatus;
      MTVEC:    csr_rdata = MTVEC_ADDR;
      MTDELEG:  csr_rdata = '0;  // No delegation
      MIE:      csr_rdata = mie;
      MSCRATCH: csr_rdata = mscratch;
      MEPC:     csr_rdata = mepc;
      MCAUSE:   csr_rdata = mcause;
      MBADADDR: csr_rdata = mbadaddr;
      MIP:      csr_rdata = mip;
      MBASE, MBOUND, MIBASE, MIBOUND, MDBASE, MDBOUND:
        csr_rdata = '0;  // Bare addressing
      HTIMEW, HTIMEHW:
        csr_rdata = '0;
      MTIMECMP: csr_rdata = mtimecmp;
      MTIME:    csr_rdata = mtime_full[31:0];
      MTIMEH:   csr_rdata = mtime_full[63:32];
      default: begin
        valid_addr = 1'b0;
        csr_rdata  = '0;
      end
    endcase
  end

  assign invalid_csr = (csr_req.op != CSR_NONE) & ~valid_addr;
  assign wr_en       = (csr_req.op != CSR_NONE) & valid_addr;

  // Read-modify-write value
  always_comb begin
    case (csr_req.op)
      CSR_SWAP: rup_data = csr_req.wdata;
      CSR_SET:  rup_data = csr_rdata | csr_req.wdata;
      CSR_CLR:  rup_data = csr_rdata & ~csr_req.wdata;
      default:  rup_data = csr_rdata;
    endcase
  end

  assign rup_mstatus = mstatus_t'(rup_data);
  assign rup_mie     = mie_t'(rup_data);

  // Only these addresses take pipeline writes
  assign wr_mstatus  = wr_en && (csr_req.addr == MSTATUS);
  assign wr_mie      = wr_en && (csr_req.addr == MIE);
  assign wr_mscratch = wr_en && (csr_req.addr == MSCRATCH);
  assign wr_mepc     = wr_en && (csr_req.addr == MEPC);
  assign wr_mtimecmp = wr_en && (csr_req.addr == MTIMECMP);
  assign wr_mtime    = wr_en && (csr_req.addr == MTIME);
  assign wr_mtimeh   = wr_en && (csr_req.addr == MTIMEH);

  assign mtime_inc       = mtime_full + 64'd1;
  assign timer_int       = (mtime_full[31:0] == mtimecmp);
  assign clear_timer_int = wr_mtimecmp;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_ie <= 1'b1;
      mie_msie   <= 1'b0;
      mie_mtie   <= 1'b0;
      mip_msip   <= 1'b0;
      mip_mtip   <= 1'b0;
      mscratch   <= '0;
      mepc       <= '0;
      mcause     <= '0;
      mbadaddr   <= '0;
      mtimecmp   <= '0;
      mtime_full <= '0;
    end else begin
      // Pipeline write beats a trap update
      if (wr_mstatus) begin
        mstatus_ie <= rup_mstatus.ie;
      end else if (csr_upd.mstatus_ie_rup) begin
        mstatus_ie <= csr_upd.mstatus_ie_next;
      end
      if (wr_mepc) begin
        mepc <= rup_data;
      end else if (csr_upd.mepc_rup) begin
        mepc <= csr_upd.mepc_next;
      end
      if (wr_mie) begin
        mie_msie <= rup_mie.msie;
        mie_mtie <= rup_mie.mtie;
      end
      if (wr_mscratch) mscratch <= rup_data;
      if (wr_mtimecmp) mtimecmp <= rup_data;
      if (csr_upd.mcause_rup) mcause <= csr_upd.mcause_next;
      if (csr_upd.mbadaddr_rup) mbadaddr <= csr_upd.mbadaddr_next;
      mip_msip <= csr_upd.mip_msip_next;
      mip_mtip <= csr_upd.mip_mtip_next;
      // Free running, a write replaces one half
      if (wr_mtime) begin
        mtime_full <= {mtime_inc[63:32], rup_data};
      end else if (wr_mtimeh) begin
        mtime_full <= {rup_data, mtime_inc[31:0]};
      end else begin
        mtime_full <= mtime_inc;
      end
    end
  end

  assign csr_view.mtvec   = MTVEC_ADDR;
  assign csr_view.mepc    = mepc;
  assign csr_view.mie     = mie;
  assign csr_view.mstatus = mstatus;
  assign csr_view.mip     = mip;

endmodule

/* hdl/prv_control.sv */
`timescale 1ns/1ns

module prv_control
  import rv32i_types_pkg::*, machine_mode_types_pkg::*;
#(
  parameter word_t MTVEC_ADDR = 32'h0000_0100
) (
  input  exc_t      exc,
  input  logic      soft_int,
  input  csr_view_t csr_view,
  input  logic      timer_int,
  input  logic      clear_timer_int,
  output csr_upd_t  csr_upd,
  output logic      trap,
  output word_t     priv_pc
);

  logic   exc_any;
  logic   timer_pend;
  logic   soft_pend;
  logic   int_any;
  logic   mret_take;
  logic   badaddr_case;
  cause_t cause;

  // Pending and enabled interrupts
  assign timer_pend = csr_view.mip.mtip & csr_view.mie.mtie;
  assign soft_pend  = csr_view.mip.msip & csr_view.mie.msie;

  assign exc_any = exc.fetch_misaligned | exc.illegal_insn | exc.breakpoint |
                   exc.ecall | exc.load_misaligned | exc.store_misaligned;

  // Global enable gates interrupts but never exceptions
  assign int_any = csr_view.mstatus.ie & (timer_pend | soft_pend);

  assign trap      = exc_any | int_any;
  assign mret_take = exc.mret & ~trap;  // A trap overrides mret

  // Highest priority cause first
  always_comb begin
    if (exc.fetch_misaligned) begin
      cause = EXC_FETCH_MISALIGNED;
    end else if (exc.illegal_insn) begin
      cause = EXC_ILLEGAL_INSN;
    end else if (exc.breakpoint) begin
      cause = EXC_BREAKPOINT;
    end else if (exc.ecall) begin
      cause = EXC_ECALL_M;
    end else if (exc.load_misaligned) begin
      cause = EXC_LOAD_MISALIGNED;
    end else if (exc.store_misaligned) begin
      cause = EXC_STORE_MISALIGNED;
    end else if (timer_pend) begin
      cause = INT_TIMER;  // Timer before software
    end else begin
      cause = INT_SOFT;
    end
  end

  // Only misaligned causes carry a bad address
  assign badaddr_case = (cause == EXC_FETCH_MISALIGNED) ||
                        (cause == EXC_LOAD_MISALIGNED)  ||
                        (cause == EXC_STORE_MISALIGNED);

  always_comb begin
    csr_upd = '0;

    // Trap clears ie, mret sets it again
    csr_upd.mstatus_ie_rup  = trap | mret_take;
    csr_upd.mstatus_ie_next = mret_take;

    csr_upd.mepc_rup  = trap;
    csr_upd.mepc_next = exc.epc;

    csr_upd.mcause_rup              = trap;
    csr_upd.mcause_next.interrupt   = cause[4];
    csr_upd.mcause_next.cause       = cause[3:0];

    csr_upd.mbadaddr_rup  = trap & badaddr_case;
    csr_upd.mbadaddr_next = exc.badaddr;

    // Software interrupt is sampled straight into mip
    csr_upd.mip_msip_next = soft_int;

    // Timer pending holds until mtimecmp is rewritten
    if (clear_timer_int) begin
      csr_upd.mip_mtip_next = 1'b0;
    end else begin
      csr_upd.mip_mtip_next = timer_int | csr_view.mip.mtip;
    end
  end

  // Redirect target
  assign priv_pc = mret_take ? csr_view.mepc : MTVEC_ADDR;

endmodule

/* hdl/priv_block.sv */
`timescale 1ns/1ns

module priv_block
  import rv32i_types_pkg::*, machine_mode_types_pkg::*;
#(
  parameter word_t MTVEC_ADDR = 32'h0000_0100
) (
  input  logic     CLK,
  input  logic     nRST,
  input  csr_req_t csr_req,
  input  exc_t     exc,
  input  logic     soft_int,
  output word_t    csr_rdata,
  output logic     invalid_csr,
  output logic     trap,
  output word_t    priv_pc
);

  csr_view_t csr_view;
  csr_upd_t  csr_upd;
  logic      timer_int;
  logic      clear_timer_int;

  // CSR storage and timer
  csr_rfile #(
    .MTVEC_ADDR(MTVEC_ADDR)
  ) u_csr_rfile (
    .CLK            (CLK),
    .nRST           (nRST),
    .csr_req        (csr_req),
    .csr_upd        (csr_upd),
    .csr_rdata      (csr_rdata),
    .invalid_csr    (invalid_csr),
    .csr_view       (csr_view),
    .timer_int      (timer_int),
    .clear_timer_int(clear_timer_int)
  );

  // Trap and return decisions
  prv_control #(
    .MTVEC_ADDR(MTVEC_ADDR)
  ) u_prv_control (
    .exc            (exc),
    .soft_int       (soft_int),
    .csr_view       (csr_view),
    .timer_int      (timer_int),
    .clear_timer_int(clear_timer_int),
    .csr_upd        (csr_upd),
    .trap           (trap),
    .priv_pc        (priv_pc)
  );

endmodule

/* verification/priv_block_props.sv */
`timescale 1ns/1ns

module priv_block_props
  import rv32i_types_pkg::*;
(
  input logic     CLK,
  input logic     nRST,
  input csr_req_t csr_req,
  input exc_t     exc,
  input logic     trap,
  input logic     invalid_csr
);

  int unsigned violations = 0;
  logic        exc_any;

  assign exc_any = exc.fetch_misaligned | exc.illegal_insn | exc.breakpoint |
                   exc.load_misaligned | exc.store_misaligned | exc.ecall;

  // Address decode only counts for a real access
  idle_no_invalid: assert property (@(posedge CLK) disable iff (!nRST)
    (csr_req.op == CSR_NONE) |-> !invalid_csr)
    else begin
      violations++;
      $error("invalid_csr high while no CSR access is requested");
    end

  // ie drops at the trap edge
  int_trap_single: assert property (@(posedge CLK) disable iff (!nRST)
    (trap && !exc_any) |=> (!trap || exc_any))
    else begin
      violations++;
      $error("interrupt trap held for more than one cycle");
    end

  reset_no_trap: assert property (@(posedge CLK) !nRST |-> !trap)
    else begin
      violations++;
      $error("trap high during reset");
    end

endmodule

bind priv_block priv_block_props u_props (
  .CLK        (CLK),
  .nRST       (nRST),
  .csr_req    (csr_req),
  .exc        (exc),
  .trap       (trap),
  .invalid_csr(invalid_csr)
);

/* verification/tb_priv_block.sv */
`timescale 1ns/1ns

module tb_priv_block
  import rv32i_types_pkg::*, machine_mode_types_pkg::*;
();

  localparam word_t MTVEC_ADDR = 32'h0000_0100;
  localparam int    MAX_VEC    = 64;
  localparam int    TRAP_WAIT  = 40;  // Cycles allowed for an expected trap
  localparam int    QUIET_WAIT = 8;   // Cycles watched when no trap is expected

  logic     CLK;
  logic     nRST;
  csr_req_t csr_req;
  exc_t     exc;
  logic     soft_int;
  word_t    csr_rdata;
  logic     invalid_csr;
  logic     trap;
  word_t    priv_pc;

  // Vectors from the golden file
  string vec_name   [0:MAX_VEC-1];
  string vec_action [0:MAX_VEC-1];
  word_t vec_addr   [0:MAX_VEC-1];
  word_t vec_wdata  [0:MAX_VEC-1];
  word_t vec_exp    [0:MAX_VEC-1];

  int vec_count   = 0;
  int pass_count  = 0;
  int fail_count  = 0;
  int cycle_count = 0;
  int cycle_limit = 200;

  priv_block #(
    .MTVEC_ADDR(MTVEC_ADDR)
  ) uut (
    .CLK        (CLK),
    .nRST       (nRST),
    .csr_req    (csr_req),
    .exc        (exc),
    .soft_int   (soft_int),
    .csr_rdata  (csr_rdata),
    .invalid_csr(invalid_csr),
    .trap       (trap),
    .priv_pc    (priv_pc)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Watchdog
  initial begin
    while (cycle_count <= cycle_limit) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("error: run exceeded its cycle limit of %0d cycles", cycle_limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic idle_inputs();
    csr_req    = '0;
    csr_req.op = CSR_NONE;
    exc        = '0;  // soft_int is a level and keeps its value
  endtask

  task automatic drive_csr(input csr_op_t op, input logic [11:0] addr, input word_t wdata);
    csr_req.op    = op;
    csr_req.addr  = addr;
    csr_req.wdata = wdata;
  endtask

  function automatic csr_op_t op_of(input string action);
    csr_op_t op;
    case (action)
      "swap":  op = CSR_SWAP;
      "set":   op = CSR_SET;
      default: op = CSR_CLR;
    endcase
    return op;
  endfunction

  // Cause code to exception flag
  function automatic exc_t build_exc(input logic [4:0] code, input word_t epc,
                                     input word_t badaddr);
    exc_t e;
    e         = '0;
    e.epc     = epc;
    e.badaddr = badaddr;
    case (code)
      5'd0:    e.fetch_misaligned = 1'b1;
      5'd2:    e.illegal_insn     = 1'b1;
      5'd3:    e.breakpoint       = 1'b1;
      5'd4:    e.load_misaligned  = 1'b1;
      5'd6:    e.store_misaligned = 1'b1;
      5'd11:   e.ecall            = 1'b1;
      default: e = '0;
    endcase
    return e;
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act,
                            inout logic ok);
    if (ok && act !== exp) begin
      $display("error: %s expected %h actual %h", name, exp, act);
      ok = 1'b0;
    end
  endtask

  task automatic fail_text(input string name, input string msg, inout logic ok);
    if (ok) begin
      $display("error: %s %s", name, msg);
      ok = 1'b0;
    end
  endtask

  // Samples 2 ns after each falling edge, starting in the current cycle
  task automatic wait_for_trap(input int limit, output logic seen);
    int n;
    seen = 1'b0;
    n    = 0;
    #2;
    while (!seen && n < limit) begin
      if (trap === 1'b1) begin
        seen = 1'b1;
      end else begin
        @(negedge CLK);
        #2;
        n++;
      end
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    n;
    string line;
    string name;
    string action;
    word_t a;
    word_t w;
    word_t e;
    fd = $fopen("verification/priv_golden.txt", "r");
    if (fd == 0) begin
      $display("error: golden file verification/priv_golden.txt could not be opened");
      fail_count++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %h", name, action, a, w, e);
          if (n == 5 && vec_count < MAX_VEC) begin
            vec_name[vec_count]   = name;
            vec_action[vec_count] = action;
            vec_addr[vec_count]   = a;
            vec_wdata[vec_count]  = w;
            vec_exp[vec_count]    = e;
            vec_count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_vector(input int idx);
    string name;
    word_t a;
    word_t w;
    word_t e;
    logic  ok;
    logic  seen;
    name = vec_name[idx];
    a    = vec_addr[idx];
    w    = vec_wdata[idx];
    e    = vec_exp[idx];
    ok   = 1'b1;
    @(negedge CLK);
    idle_inputs();
    case (vec_action[idx])
      "read": begin
        drive_csr(CSR_SET, a[11:0], '0);  // Set with zero leaves the CSR as is
        #2;
        check_word(name, e, csr_rdata, ok);
        check_word(name, w, {31'd0, invalid_csr}, ok);
      end
      "swap", "set", "clr": begin
        drive_csr(op_of(vec_action[idx]), a[11:0], w);
        #2;
        check_word(name, e, csr_rdata, ok);  // Old value comes back
        check_word(name, 32'd0, {31'd0, invalid_csr}, ok);
      end
      "exc": begin
        exc = build_exc(a[4:0], w, e);
        #2;
        check_word(name, 32'd1, {31'd0, trap}, ok);
        check_word(name, MTVEC_ADDR, priv_pc, ok);
      end
      "mret": begin
        exc.mret = 1'b1;
        #2;
        check_word(name, 32'd0, {31'd0, trap}, ok);
        check_word(name, e, priv_pc, ok);
      end
      "softint": begin
        soft_int = w[0];
        wait_for_trap(e[0] ? TRAP_WAIT : QUIET_WAIT, seen);
        if (seen !== e[0]) begin
          fail_text(name, e[0] ? "no software interrupt trap was taken" :
                                 "a trap was taken while none was expected", ok);
        end
        if (seen) check_word(name, MTVEC_ADDR, priv_pc, ok);
        @(negedge CLK);
        drive_csr(CSR_SET, MIP, '0);  // msip sits at bit 3 of mip
        #2;
        check_word(name, {28'd0, w[0], 3'd0}, csr_rdata & 32'h0000_0008, ok);
      end
      "timer": begin
        drive_csr(CSR_SWAP, MTIME, w);
        @(negedge CLK);
        drive_csr(CSR_SWAP, MTIMECMP, e);
        @(negedge CLK);
        drive_csr(CSR_SET, MIE, 32'h0000_0080);  // mtie is bit 7
        @(negedge CLK);
        idle_inputs();
        wait_for_trap(TRAP_WAIT, seen);
        if (!seen) fail_text(name, "no timer interrupt trap within 40 cycles", ok);
        check_word(name, MTVEC_ADDR, priv_pc, ok);
      end
      default: fail_text(name, "has an unknown action in the golden file", ok);
    endcase
    if (ok) begin
      pass_count++;
      $display("passed: %s", name);
    end else begin
      fail_count++;
    end
  endtask

  initial begin
    nRST     = 1'b0;
    soft_int = 1'b0;
    idle_inputs();
    load_vectors();
    cycle_limit = 40 * vec_count + 200;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    for (int i = 0; i < vec_count; i++) begin
      run_vector(i);
    end
    if (uut.u_props.violations != 0) begin
      $display("error: %0d property violations were reported", uut.u_props.violations);
      fail_count++;
    end
    $display("tests run %0d, passed %0d, failed %0d", vec_count, pass_count, fail_count);
    if (fail_count == 0 && vec_count > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verification/priv_golden.txt */
# columns: name action addr wdata expected, numbers in hex
# read: wdata is the expected invalid_csr; exc: addr is the cause, wdata epc, expected badaddr
# mret: expected priv_pc; softint: wdata is the level, expected 1 if a trap must follow
# timer: wdata is the new mtime, expected the new mtimecmp
id_mcpuid      read    f00 0        00000100
id_mtvec       read    301 0        00000100
id_mbase       read    380 0        00000000
id_mstatus     read    300 0        00000db7
rmw_swap       swap    340 12345678 00000000
rmw_swap_rd    read    340 0        12345678
rmw_set        set     340 0000ff00 12345678
rmw_clr        clr     340 00000078 1234ff78
rmw_clr_rd     read    340 0        1234ff00
rmw_mepc       swap    341 00000400 00000000
bad_addr       read    123 1        00000000
exc_illegal    exc     2   00000500 deadbeef
exc_ill_mepc   read    341 0        00000500
exc_ill_mcause read    342 0        00000002
exc_ill_bad    read    343 0        00000000
exc_load       exc     4   00000504 00001001
exc_ld_mepc    read    341 0        00000504
exc_ld_mcause  read    342 0        00000004
exc_ld_bad     read    343 0        00001001
exc_ld_mstatus read    300 0        00000db6
mret_ret       mret    0   0        00000504
mret_mstatus   read    300 0        00000db7
timer_irq      timer   0   00001000 00001014
tmr_mcause     read    342 0        80000001
tmr_mip        read    344 0        00000080
tmr_cmp        swap    321 ffff0000 00001014
tmr_mip_clr    read    344 0        00000000
tmr_mie_off    clr     304 00000080 00000080
tmr_ie_on      set     300 00000001 00000db6
soft_masked    softint 0   1        0
soft_mip       read    344 0        00000008
soft_enable    set     304 00000008 00000000
soft_irq       softint 0   1        1
soft_mcause    read    342 0        80000000
soft_release   softint 0   0        0

/* filelist.f */
hdl/rv32i_types_pkg.sv
hdl/machine_mode_types_pkg.sv
hdl/csr_rfile.sv
hdl/prv_control.sv
hdl/priv_block.sv
verification/priv_block_props.sv
verification/tb_priv_block.sv
